/* hw/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define WORD_SIZE 16

// Architectural registers
`define NUM_REGS 4

// First fetch address
`define RESET_PC 16'h0000

`endif

/* hw/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funct_e;

	// Nine operations, so four bits
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B
	} alu_func_e;

	// Second ALU operand source
	typedef enum logic [1:0] {
		SRC_REG,
		SRC_SEXT,
		SRC_ZEXT,
		SRC_UPPER
	} alu_src_e;

	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_WB = 2'd1,
		FWD_MEM = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		alu_func_e alu_func;
		alu_src_e alu_src;
		reg_idx_t dest;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic is_wwd;
		logic is_halt;
		logic valid;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t read_out1;
		word_t read_out2;
		logic [7:0] imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t read_data;
	} mem_wb_t;

endpackage

/* hw/control.sv */
`timescale 1ns/1ps

module control (
	input cpu_pkg::word_t instruction,
	input logic valid_in,
	output cpu_pkg::ctrl_t ctrl,
	output logic halt
);
	import cpu_pkg::*;

	logic [3:0] opcode;
	logic [5:0] funct;
	reg_idx_t rt;
	reg_idx_t rd;

	assign opcode = instruction[15:12];
	assign funct = instruction[5:0];
	assign rt = instruction[9:8];
	assign rd = instruction[7:6];

	always_comb begin
		ctrl = '0;
		ctrl.alu_func = ALU_ADD;
		ctrl.alu_src = SRC_REG;
		ctrl.dest = rt;
		halt = 1'b0;
		if (valid_in) begin
			ctrl.valid = 1'b1;
			case (opcode)
				OP_ADI: begin
					ctrl.alu_src = SRC_SEXT;
					ctrl.reg_write = 1'b1;
				end
				OP_ORI: begin
					ctrl.alu_func = ALU_OR;
					ctrl.alu_src = SRC_ZEXT;
					ctrl.reg_write = 1'b1;
				end
				OP_LHI: begin
					ctrl.alu_func = ALU_PASS_B;
					ctrl.alu_src = SRC_UPPER;
					ctrl.reg_write = 1'b1;
				end
				OP_LWD: begin
					ctrl.alu_src = SRC_SEXT;
					ctrl.reg_write = 1'b1;
					ctrl.mem_read = 1'b1;
					ctrl.mem_to_reg = 1'b1;
				end
				OP_SWD: begin
					ctrl.alu_src = SRC_SEXT;
					ctrl.mem_write = 1'b1;
				end
				OP_RTYPE: begin
					ctrl.dest = rd;
					ctrl.reg_write = 1'b1;
					case (funct)
						FN_ADD: ctrl.alu_func = ALU_ADD;
						FN_SUB: ctrl.alu_func = ALU_SUB;
						FN_AND: ctrl.alu_func = ALU_AND;
						FN_ORR: ctrl.alu_func = ALU_OR;
						FN_NOT: ctrl.alu_func = ALU_NOT;
						FN_TCP: ctrl.alu_func = ALU_TCP;
						FN_SHL: ctrl.alu_func = ALU_SHL;
						FN_SHR: ctrl.alu_func = ALU_SHR;
						FN_WWD: begin
							ctrl.reg_write = 1'b0;
							ctrl.is_wwd = 1'b1;
						end
						FN_HLT: begin
							ctrl.reg_write = 1'b0;
							ctrl.is_halt = 1'b1;
							halt = 1'b1;
						end
						default: ctrl = '0;
					endcase
				end
				// Unknown opcode leaves a bubble
				default: ctrl = '0;
			endcase
		end
	end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file (
	input logic Clk,
	input logic rst_n,
	input cpu_pkg::reg_idx_t read1,
	input cpu_pkg::reg_idx_t read2,
	input cpu_pkg::reg_idx_t write_reg,
	input cpu_pkg::word_t write_data,
	input logic reg_write,
	output cpu_pkg::word_t read_out1,
	output cpu_pkg::word_t read_out2
);
	import cpu_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

	// Write-first bypass covers the distance-3 dependency
	assign read_out1 = (reg_write && write_reg == read1) ? write_data : regs[read1];
	assign read_out2 = (reg_write && write_reg == read2) ? write_data : regs[read2];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::alu_func_e func,
	output cpu_pkg::word_t c
);
	import cpu_pkg::*;

	always_comb begin
		case (func)
			ALU_ADD: c = a + b;
			ALU_SUB: c = a - b;
			ALU_AND: c = a & b;
			ALU_OR: c = a | b;
			ALU_NOT: c = ~a;
			ALU_TCP: c = ~a + word_t'(1);
			ALU_SHL: c = a << 1;
			// Arithmetic, keeps the sign bit
			ALU_SHR: c = word_t'($signed(a) >>> 1);
			ALU_PASS_B: c = b;
			default: c = '0;
		endcase
	end

endmodule

/* hw/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit (
	input cpu_pkg::reg_idx_t id_ex_rs,
	input cpu_pkg::reg_idx_t id_ex_rt,
	input cpu_pkg::reg_idx_t ex_mem_dest,
	input cpu_pkg::reg_idx_t mem_wb_dest,
	input logic ex_mem_reg_write,
	input logic mem_wb_reg_write,
	output cpu_pkg::fwd_sel_e fwd_a,
	output cpu_pkg::fwd_sel_e fwd_b
);
	import cpu_pkg::*;

	// Youngest producer wins
	function automatic fwd_sel_e pick(input reg_idx_t src);
		fwd_sel_e sel;
		sel = FWD_RF;
		if (ex_mem_reg_write && ex_mem_dest == src) begin
			sel = FWD_MEM;
		end else if (mem_wb_reg_write && mem_wb_dest == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwd_a = pick(id_ex_rs);
	assign fwd_b = pick(id_ex_rt);

endmodule

/* hw/cpu.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu (
	input logic Clk,
	input logic rst_n,
	output logic readM1,
	output cpu_pkg::word_t address1,
	input cpu_pkg::word_t data1,
	output logic readM2,
	output logic writeM2,
	output cpu_pkg::word_t address2,
	inout wire cpu_pkg::word_t data2,
	output cpu_pkg::word_t num_inst,
	output cpu_pkg::word_t output_port,
	output logic is_halted
);
	import cpu_pkg::*;

	word_t pc;
	logic fetch_stop;

	word_t if_id_instr;
	logic if_id_valid;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	ctrl_t dec_ctrl;
	logic dec_halt;
	reg_idx_t dec_rs;
	reg_idx_t dec_rt;
	word_t read_out1;
	word_t read_out2;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t wb_data;
	word_t op_a;
	word_t reg_b;
	word_t imm_ext;
	word_t op_b;
	word_t alu_c;
	word_t ex_result;

	assign dec_rs = if_id_instr[11:10];
	assign dec_rt = if_id_instr[9:8];

	control u_control (
		.instruction(if_id_instr),
		.valid_in(if_id_valid),
		.ctrl(dec_ctrl),
		.halt(dec_halt)
	);

	register_file u_register_file (
		.Clk(Clk),
		.rst_n(rst_n),
		.read1(dec_rs),
		.read2(dec_rt),
		.write_reg(mem_wb.ctrl.dest),
		.write_data(wb_data),
		.reg_write(mem_wb.ctrl.reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	forwarding_unit u_forwarding_unit (
		.id_ex_rs(id_ex.rs),
		.id_ex_rt(id_ex.rt),
		.ex_mem_dest(ex_mem.ctrl.dest),
		.mem_wb_dest(mem_wb.ctrl.dest),
		.ex_mem_reg_write(ex_mem.ctrl.reg_write),
		.mem_wb_reg_write(mem_wb.ctrl.reg_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	// Writeback value, also the MEM/WB forward source
	assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

	always_comb begin
		case (fwd_a)
			FWD_MEM: op_a = ex_mem.alu_result;
			FWD_WB: op_a = wb_data;
			default: op_a = id_ex.read_out1;
		endcase
		case (fwd_b)
			FWD_MEM: reg_b = ex_mem.alu_result;
			FWD_WB: reg_b = wb_data;
			default: reg_b = id_ex.read_out2;
		endcase
	end

	always_comb begin
		case (id_ex.ctrl.alu_src)
			SRC_SEXT: imm_ext = {{(`WORD_SIZE-8){id_ex.imm[7]}}, id_ex.imm};
			SRC_ZEXT: imm_ext = {{(`WORD_SIZE-8){1'b0}}, id_ex.imm};
			SRC_UPPER: imm_ext = {id_ex.imm, {(`WORD_SIZE-8){1'b0}}};
			default: imm_ext = '0;
		endcase
	end

	assign op_b = (id_ex.ctrl.alu_src == SRC_REG) ? reg_b : imm_ext;

	alu u_alu (
		.a(op_a),
		.b(op_b),
		.func(id_ex.ctrl.alu_func),
		.c(alu_c)
	);

	// WWD carries rs down the pipe in the result slot
	assign ex_result = id_ex.ctrl.is_wwd ? op_a : alu_c;

	// Memory interface
	assign readM1 = rst_n && !is_halted;
	assign address1 = pc;
	assign readM2 = ex_mem.ctrl.mem_read;
	assign writeM2 = ex_mem.ctrl.mem_write;
	assign address2 = ex_mem.alu_result;
	assign data2 = ex_mem.ctrl.mem_write ? ex_mem.store_data : 'z;

	// Fetch, stops for good once HLT is decoded
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
			fetch_stop <= 1'b0;
			if_id_instr <= '0;
			if_id_valid <= 1'b0;
		end else begin
			if (dec_halt) begin
				fetch_stop <= 1'b1;
			end
			if (dec_halt || fetch_stop) begin
				if_id_valid <= 1'b0;
			end else begin
				pc <= pc + word_t'(1);
				if_id_instr <= data1;
				if_id_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			id_ex <= '{
				ctrl: dec_ctrl,
				rs: dec_rs,
				rt: dec_rt,
				read_out1: read_out1,
				read_out2: read_out2,
				imm: if_id_instr[7:0]
			};
			ex_mem <= '{ctrl: id_ex.ctrl, alu_result: ex_result, store_data: reg_b};
			mem_wb <= '{ctrl: ex_mem.ctrl, alu_result: ex_mem.alu_result, read_data: data2};
		end
	end

	// Retire side
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (mem_wb.ctrl.valid) begin
			num_inst <= num_inst + word_t'(1);
			if (mem_wb.ctrl.is_wwd) begin
				output_port <= mem_wb.alu_result;
			end
			if (mem_wb.ctrl.is_halt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

/* testbench/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties (
	input logic Clk,
	input logic rst_n,
	input logic readM2,
	input logic writeM2,
	input logic is_halted,
	input cpu_pkg::word_t num_inst
);

	int failures = 0;

	// One data bus, one direction at a time
	strobes_exclusive: assert property (
		@(posedge Clk) disable iff (!rst_n) !(readM2 && writeM2)
	) else begin
		$error("readM2 and writeM2 are high in the same cycle");
		failures++;
	end

	halt_sticky: assert property (
		@(posedge Clk) disable iff (!rst_n) is_halted |=> is_halted
	) else begin
		$error("is_halted fell while out of reset");
		failures++;
	end

	retire_step: assert property (
		@(posedge Clk) disable iff (!rst_n)
		1'b1 |=> (num_inst == $past(num_inst) || num_inst == $past(num_inst) + 16'd1)
	) else begin
		$error("num_inst rose by more than one in a cycle");
		failures++;
	end

	// Latches still hold bubbles on the first edge out of reset
	quiet_after_reset: assert property (
		@(posedge Clk) $rose(rst_n) |-> (!readM2 && !writeM2)
	) else begin
		$error("Data strobe active in the first cycle after reset");
		failures++;
	end

endmodule

bind cpu cpu_properties u_cpu_properties (
	.Clk(Clk),
	.rst_n(rst_n),
	.readM2(readM2),
	.writeM2(writeM2),
	.is_halted(is_halted),
	.num_inst(num_inst)
);

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int PROG_LEN = 64;
	localparam int DMEM_WORDS = 256;
	localparam int RESET_CYCLES = 10;
	// Reset, then two cycles per instruction with slack for fill and drain
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * (PROG_LEN + 10);
	localparam int DRAIN_CYCLES = 8;

	logic Clk;
	logic rst_n;
	logic readM1;
	word_t address1;
	word_t data1;
	logic readM2;
	logic writeM2;
	word_t address2;
	wire [15:0] data2;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t prog [PROG_LEN];
	word_t dmem [DMEM_WORDS];

	// Sequential model state
	word_t ref_regs [4];
	word_t ref_mem [DMEM_WORDS];
	word_t exp_wwd [$];
	int exp_retired;

	logic [31:0] rng_state;
	word_t expected_port = '0;
	int wwd_index = 0;
	int seen_retired = 0;
	int cycle_count = 0;
	int check_count = 0;
	int port_errors = 0;
	int count_errors = 0;
	int mem_errors = 0;
	int other_errors = 0;

	cpu DUT (
		.Clk(Clk),
		.rst_n(rst_n),
		.readM1(readM1),
		.address1(address1),
		.data1(data1),
		.readM2(readM2),
		.writeM2(writeM2),
		.address2(address2),
		.data2(data2),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	initial begin
		Clk = 1'b0;
		forever begin
			#2 Clk = ~Clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic word_t dmem_fill(input int addr);
		logic [7:0] a;
		a = addr[7:0];
		return {a ^ 8'h3c, ~a};
	endfunction

	function automatic word_t enc_rtype(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic word_t enc_itype(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic bit is_wwd(input word_t instr);
		return instr[15:12] == OP_RTYPE && instr[5:0] == FN_WWD;
	endfunction

	// Source register, kept off the previous load's destination
	function automatic logic [1:0] pick_src(input bit avoid, input logic [1:0] skip);
		logic [1:0] r;
		r = 2'(next_rand() % 4);
		if (avoid && r == skip) begin
			r = r + 2'd1;
		end
		return r;
	endfunction

	function automatic void reset_model();
		int i;
		exp_wwd.delete();
		for (i = 0; i < 4; i++) begin
			ref_regs[i] = '0;
		end
		for (i = 0; i < DMEM_WORDS; i++) begin
			ref_mem[i] = dmem_fill(i);
		end
	endfunction

	// One instruction in program order, returns 1 on HLT
	function automatic bit isa_step(input word_t instr);
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		word_t a;
		word_t b;
		word_t imm_s;
		word_t addr;
		bit halted;
		rs = instr[11:10];
		rt = instr[9:8];
		rd = instr[7:6];
		a = ref_regs[rs];
		b = ref_regs[rt];
		imm_s = {{8{instr[7]}}, instr[7:0]};
		addr = a + imm_s;
		halted = 1'b0;
		case (instr[15:12])
			OP_ADI: ref_regs[rt] = a + imm_s;
			OP_ORI: ref_regs[rt] = a | {8'h00, instr[7:0]};
			OP_LHI: ref_regs[rt] = {instr[7:0], 8'h00};
			OP_LWD: ref_regs[rt] = ref_mem[addr[7:0]];
			OP_SWD: ref_mem[addr[7:0]] = b;
			OP_RTYPE: begin
				case (instr[5:0])
					FN_ADD: ref_regs[rd] = a + b;
					FN_SUB: ref_regs[rd] = a - b;
					FN_AND: ref_regs[rd] = a & b;
					FN_ORR: ref_regs[rd] = a | b;
					FN_NOT: ref_regs[rd] = ~a;
					FN_TCP: ref_regs[rd] = 16'd0 - a;
					FN_SHL: ref_regs[rd] = {a[14:0], 1'b0};
					FN_SHR: ref_regs[rd] = {a[15], a[15:1]};
					FN_WWD: exp_wwd.push_back(a);
					FN_HLT: halted = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
		return halted;
	endfunction

	function automatic int reference_run();
		int pc;
		int retired;
		bit done;
		reset_model();
		retired = 0;
		done = 1'b0;
		for (pc = 0; pc < PROG_LEN && !done; pc++) begin
			done = isa_step(prog[pc]);
			retired++;
		end
		return retired;
	endfunction

	function automatic void generate_program();
		int i;
		int kind;
		int imm;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		word_t instr;
		bit avoid;
		logic [1:0] avoid_reg;
		reset_model();
		avoid = 1'b0;
		avoid_reg = 2'd0;
		for (i = 0; i < PROG_LEN - 1; i++) begin
			kind = next_rand() % 16;
			rs = pick_src(avoid, avoid_reg);
			rt = pick_src(avoid, avoid_reg);
			rd = 2'(next_rand() % 4);
			if (kind < 4) begin
				instr = enc_rtype(rs, rt, rd, FN_WWD);
			end else if (kind < 10) begin
				instr = enc_rtype(rs, rt, rd, 6'(next_rand() % 8));
			end else if (kind == 10) begin
				instr = enc_itype(OP_ADI, rs, rt, 8'(next_rand()));
			end else if (kind == 11) begin
				instr = enc_itype(OP_ORI, rs, rt, 8'(next_rand()));
			end else if (kind == 12) begin
				instr = enc_itype(OP_LHI, rs, rt, 8'(next_rand()));
			end else if (ref_regs[rs] > 16'd127) begin
				// Base too large, clear it first
				instr = enc_itype(OP_LHI, rs, rs, 8'h00);
			end else begin
				imm = int'(next_rand() % 16) - int'(ref_regs[rs]);
				instr = enc_itype(kind == 15 ? OP_SWD : OP_LWD, rs, rt, 8'(imm));
			end
			prog[i] = instr;
			void'(isa_step(instr));
			avoid = (instr[15:12] == OP_LWD);
			avoid_reg = instr[9:8];
		end
		prog[PROG_LEN - 1] = enc_rtype(2'd0, 2'd0, 2'd0, FN_HLT);
	endfunction

	// Fetch port answers only while readM1 is high
	// Address-dependent ADI words past the program
	assign data1 = !readM1 ? 16'hxxxx :
		(address1 < PROG_LEN) ? prog[address1[5:0]] :
		{OP_ADI, address1[11:0] ^ {8'h00, address1[15:12]}};

	assign data2 = readM2 ? dmem[address2[7:0]] : 16'hzzzz;

	always @(negedge Clk) begin
		if (rst_n && (readM2 || writeM2)) begin
			assert (address2 < DMEM_WORDS) else begin
				$display("Data access outside the data memory at %0t, address %h",
					$time, address2);
				other_errors++;
			end
		end
		if (rst_n && writeM2) begin
			dmem[address2[7:0]] = data2;
		end
	end

	// One retired instruction per num_inst step
	always @(negedge Clk) begin
		if (rst_n && num_inst != word_t'(seen_retired)) begin
			seen_retired++;
			assert (seen_retired <= exp_retired) else begin
				$display("Instruction %0d retired after HLT at %0t", seen_retired, $time);
				other_errors++;
			end
			if (seen_retired <= PROG_LEN && is_wwd(prog[seen_retired - 1])) begin
				if (wwd_index < exp_wwd.size()) begin
					expected_port = exp_wwd[wwd_index];
				end
				wwd_index++;
			end
			check_count++;
			assert (output_port == expected_port) else begin
				$display("ERROR at %0t: output_port = %h, expected %h",
					$time, output_port, expected_port);
				port_errors++;
			end
		end
	end

	task automatic check_final_state();
		int a;
		check_count++;
		assert (num_inst == word_t'(exp_retired)) else begin
			$display("ERROR at %0t: num_inst = %0d, expected %0d", $time, num_inst, exp_retired);
			count_errors++;
		end
		check_count++;
		assert (output_port == expected_port) else begin
			$display("ERROR at %0t: output_port = %h, expected %h",
				$time, output_port, expected_port);
			port_errors++;
		end
		assert (wwd_index == exp_wwd.size()) else begin
			$display("Only %0d of %0d WWD results were seen", wwd_index, exp_wwd.size());
			other_errors++;
		end
		assert (readM1 == 1'b0) else begin
			$display("Fetch is still active after halt");
			other_errors++;
		end
		for (a = 0; a < DMEM_WORDS; a++) begin
			check_count++;
			assert (dmem[a] == ref_mem[a]) else begin
				$display("ERROR at %0t: dmem[%0d] = %h, expected %h", $time, a, dmem[a], ref_mem[a]);
				mem_errors++;
			end
		end
	endtask

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge Clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles without is_halted", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int i;
		int total;
		int prop_errors;
		rst_n = 1'b0;
		rng_state = 32'hbe37_d5c4;
		for (i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = dmem_fill(i);
		end
		generate_program();
		exp_retired = reference_run();
		repeat (RESET_CYCLES) @(posedge Clk);
		@(negedge Clk);
		rst_n = 1'b1;
		while (is_halted !== 1'b1) begin
			@(negedge Clk);
		end
		check_count++;
		assert (num_inst == word_t'(exp_retired)) else begin
			$display("ERROR at %0t: num_inst = %0d, expected %0d", $time, num_inst, exp_retired);
			count_errors++;
		end
		// Nothing younger than HLT may retire or store
		repeat (DRAIN_CYCLES) @(negedge Clk);
		check_final_state();
		prop_errors = DUT.u_cpu_properties.failures;
		total = port_errors + count_errors + mem_errors + other_errors + prop_errors;
		$display("Summary: %0d checks, errors %0d port %0d count %0d mem %0d prop %0d other",
			check_count, port_errors, count_errors, mem_errors, prop_errors, other_errors);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+hw
hw/cpu_pkg.sv
hw/control.sv
hw/register_file.sv
hw/alu.sv
hw/forwarding_unit.sv
hw/cpu.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu16_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/control.sv
      - hw/register_file.sv
      - hw/alu.sv
      - hw/forwarding_unit.sv
      - hw/cpu.sv
  - target: test
    files:
      - testbench/cpu_properties.sv
      - testbench/cpu_tb.sv
